/* dspPkg.sv */
package dspPkg;

    //**************************************************************************
    // Sample path widths
    //**************************************************************************

    // Soft samples from the demodulator and trellis decoder
    localparam int SAMPLE_WIDTH = 18;

    // DAC parallel data bus
    localparam int DAC_CODE_WIDTH = 14;

    // Raw source-select field as stored in the register block
    localparam int SOURCE_SEL_WIDTH = 4;

    typedef logic signed [SAMPLE_WIDTH-1:0] sampleT;
    typedef logic [DAC_CODE_WIDTH-1:0] dacCodeT;
    typedef logic [SOURCE_SEL_WIDTH-1:0] sourceSelT;

    //**************************************************************************
    // Source selects
    //**************************************************************************

    // DAC sources, anything else falls back to demod
    typedef enum sourceSelT {
        DAC_SRC_DEMOD   = 4'd0,
        DAC_SRC_TRELLIS = 4'd1
    } dacSourceE;

    // Clock-and-data sources, anything else falls back to legacy I
    typedef enum sourceSelT {
        CD_SRC_LEGACY_I = 4'd0,
        CD_SRC_LEGACY_Q = 4'd1,
        CD_SRC_TRELLIS  = 4'd2
    } clkDataSourceE;

    // Offset-binary code of a zero sample
    localparam dacCodeT DAC_MIDSCALE = 14'h2000;

endpackage

/* regMapPkg.sv */
package regMapPkg;

    //**************************************************************************
    // Register bus
    //**************************************************************************

    localparam int REG_ADDR_WIDTH = 4;
    localparam int REG_DATA_WIDTH = 16;

    typedef logic [REG_ADDR_WIDTH-1:0] regAddrT;
    typedef logic [REG_DATA_WIDTH-1:0] regDataT;

    //**************************************************************************
    // Register map
    //**************************************************************************

    // Read only, returns the build version
    localparam regAddrT ADDR_VERSION = 4'd0;

    // DAC source selects
    localparam regAddrT ADDR_DAC0_SOURCE = 4'd1;
    localparam regAddrT ADDR_DAC1_SOURCE = 4'd2;

    // Clock-and-data channel source selects
    localparam regAddrT ADDR_CH0_SOURCE = 4'd3;
    localparam regAddrT ADDR_CH1_SOURCE = 4'd4;

    // Reset value of every source select
    localparam dspPkg::sourceSelT SOURCE_RESET = '0;

endpackage

/* routerRegs.sv */
`timescale 1ns/10ps

module routerRegs #(
    parameter regMapPkg::regDataT VersionNumber = 16'h0000
) (
    input  logic                clk,
    input  logic                reset,

    // Register bus
    input  logic                regWrite,
    input  logic                regRead,
    input  regMapPkg::regAddrT  regAddr,
    input  regMapPkg::regDataT  regWriteData,
    output regMapPkg::regDataT  regReadData,
    output logic                regReadValid,

    // Source selects to the output paths
    output dspPkg::sourceSelT   dac0Source,
    output dspPkg::sourceSelT   dac1Source,
    output dspPkg::sourceSelT   ch0Source,
    output dspPkg::sourceSelT   ch1Source
);

    //**************************************************************************
    // Write decode
    //**************************************************************************

    // Only the low bits of the bus land in a source register
    dspPkg::sourceSelT writeField;
    assign writeField = regWriteData[dspPkg::SOURCE_SEL_WIDTH-1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            dac0Source <= regMapPkg::SOURCE_RESET;
            dac1Source <= regMapPkg::SOURCE_RESET;
            ch0Source <= regMapPkg::SOURCE_RESET;
            ch1Source <= regMapPkg::SOURCE_RESET;
        end
        else if (regWrite) begin
            case (regAddr)
                regMapPkg::ADDR_DAC0_SOURCE: begin
                    dac0Source <= writeField;
                end
                regMapPkg::ADDR_DAC1_SOURCE: begin
                    dac1Source <= writeField;
                end
                regMapPkg::ADDR_CH0_SOURCE: begin
                    ch0Source <= writeField;
                end
                regMapPkg::ADDR_CH1_SOURCE: begin
                    ch1Source <= writeField;
                end
                // Version and unmapped addresses ignore writes
                default: begin
                end
            endcase
        end
    end

    //**************************************************************************
    // Read path
    //**************************************************************************

    regMapPkg::regDataT readMux;

    always_comb begin
        case (regAddr)
            regMapPkg::ADDR_VERSION:     readMux = VersionNumber;
            regMapPkg::ADDR_DAC0_SOURCE: readMux = regMapPkg::regDataT'(dac0Source);
            regMapPkg::ADDR_DAC1_SOURCE: readMux = regMapPkg::regDataT'(dac1Source);
            regMapPkg::ADDR_CH0_SOURCE:  readMux = regMapPkg::regDataT'(ch0Source);
            regMapPkg::ADDR_CH1_SOURCE:  readMux = regMapPkg::regDataT'(ch1Source);
            default:                     readMux = '0;
        endcase
    end

    // Data is captured with the pre-write register values
    always_ff @(posedge clk) begin
        if (regRead) begin
            regReadData <= readMux;
        end
    end

    // One-cycle valid strobe behind each read
    always_ff @(posedge clk) begin
        if (reset) begin
            regReadValid <= 1'b0;
        end
        else begin
            regReadValid <= regRead;
        end
    end

endmodule

/* dacPath.sv */
`timescale 1ns/10ps

module dacPath (
    input  logic                clk,
    input  logic                reset,

    // Candidate sample streams
    input  logic                demodEn,
    input  dspPkg::sampleT      demodData,
    input  logic                trellisEn,
    input  dspPkg::sampleT      trellisData,

    input  dspPkg::sourceSelT   dacSource,
    output dspPkg::dacCodeT     dacD
);

    //**************************************************************************
    // Stage 1, registered source mux
    //**************************************************************************

    logic           selEn;
    dspPkg::sampleT selData;

    always_ff @(posedge clk) begin
        if (reset) begin
            selEn <= 1'b0;
        end
        else begin
            case (dacSource)
                dspPkg::DAC_SRC_TRELLIS: selEn <= trellisEn;
                default:                 selEn <= demodEn;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (dacSource)
            dspPkg::DAC_SRC_TRELLIS: selData <= trellisData;
            default:                 selData <= demodData;
        endcase
    end

    //**************************************************************************
    // Stage 2, sample hold
    //**************************************************************************

    // Starts at zero so the DAC sits at midscale until the first strobe
    dspPkg::sampleT holdData;

    always_ff @(posedge clk) begin
        if (reset) begin
            holdData <= '0;
        end
        else if (selEn) begin
            holdData <= selData;
        end
    end

    //**************************************************************************
    // Stage 3, offset-binary output
    //**************************************************************************

    // Flip the sign bit and keep the top magnitude bits
    always_ff @(posedge clk) begin
        if (reset) begin
            dacD <= dspPkg::DAC_MIDSCALE;
        end
        else begin
            dacD <= {~holdData[dspPkg::SAMPLE_WIDTH-1],
                     holdData[dspPkg::SAMPLE_WIDTH-2 -: dspPkg::DAC_CODE_WIDTH-1]};
        end
    end

endmodule

/* clkDataOutput.sv */
`timescale 1ns/10ps

module clkDataOutput (
    input  logic                clk,
    input  logic                reset,

    // Legacy I stream
    input  logic                iSymEn,
    input  logic                iSym2xEn,
    input  logic                iBit,

    // Legacy Q stream
    input  logic                qSymEn,
    input  logic                qSym2xEn,
    input  logic                qBit,

    // Trellis decoder stream
    input  logic                trellisSymEn,
    input  logic                trellisSym2xEn,
    input  logic                trellisBit,

    input  dspPkg::sourceSelT   chSource,
    output logic                chClkOut,
    output logic                chDataOut
);

    //**************************************************************************
    // Stream select
    //**************************************************************************

    logic selSymEn;
    logic selSym2xEn;
    logic selBit;

    always_comb begin
        case (chSource)
            dspPkg::CD_SRC_LEGACY_Q: begin
                selSymEn = qSymEn;
                selSym2xEn = qSym2xEn;
                selBit = qBit;
            end
            dspPkg::CD_SRC_TRELLIS: begin
                selSymEn = trellisSymEn;
                selSym2xEn = trellisSym2xEn;
                selBit = trellisBit;
            end
            // Legacy I, also any undefined select
            default: begin
                selSymEn = iSymEn;
                selSym2xEn = iSym2xEn;
                selBit = iBit;
            end
        endcase
    end

    //**************************************************************************
    // Clock and data launch
    //**************************************************************************

    // Falling clock edge launches the bit, rising edge at mid symbol
    // gives the sink a full half period of setup
    always_ff @(posedge clk) begin
        if (reset) begin
            chClkOut <= 1'b0;
            chDataOut <= 1'b0;
        end
        else if (selSymEn) begin
            chClkOut <= 1'b0;
            chDataOut <= selBit;
        end
        else if (selSym2xEn) begin
            chClkOut <= 1'b1;
        end
    end

endmodule

/* demodOutputRouter.sv */
`timescale 1ns/10ps

module demodOutputRouter #(
    parameter regMapPkg::regDataT VersionNumber = 16'h0000
) (
    input  logic                clk,
    input  logic                reset,

    // Register bus
    input  logic                regWrite,
    input  logic                regRead,
    input  regMapPkg::regAddrT  regAddr,
    input  regMapPkg::regDataT  regWriteData,
    output regMapPkg::regDataT  regReadData,
    output logic                regReadValid,

    // DAC sample streams
    input  logic                demodDac0En,
    input  dspPkg::sampleT      demodDac0Data,
    input  logic                trellisDac0En,
    input  dspPkg::sampleT      trellisDac0Data,
    input  logic                demodDac1En,
    input  dspPkg::sampleT      demodDac1Data,
    input  logic                trellisDac1En,
    input  dspPkg::sampleT      trellisDac1Data,

    // Decided bits and symbol strobes
    input  logic                iSymEn,
    input  logic                iSym2xEn,
    input  logic                iBit,
    input  logic                qSymEn,
    input  logic                qSym2xEn,
    input  logic                qBit,
    input  logic                trellisSymEn,
    input  logic                trellisSym2xEn,
    input  logic                trellisBit,

    // Board outputs
    output dspPkg::dacCodeT     dac0D,
    output dspPkg::dacCodeT     dac1D,
    output logic                ch0ClkOut,
    output logic                ch0DataOut,
    output logic                ch1ClkOut,
    output logic                ch1DataOut
);

    //**************************************************************************
    // Register block
    //**************************************************************************

    dspPkg::sourceSelT dac0Source;
    dspPkg::sourceSelT dac1Source;
    dspPkg::sourceSelT ch0Source;
    dspPkg::sourceSelT ch1Source;

    routerRegs #(.VersionNumber(VersionNumber)) regs (
        .clk(clk), .reset(reset),
        .regWrite(regWrite), .regRead(regRead),
        .regAddr(regAddr), .regWriteData(regWriteData),
        .regReadData(regReadData), .regReadValid(regReadValid),
        .dac0Source(dac0Source), .dac1Source(dac1Source),
        .ch0Source(ch0Source), .ch1Source(ch1Source)
    );

    //**************************************************************************
    // DAC outputs
    //**************************************************************************

    dacPath dac0Path (
        .clk(clk), .reset(reset),
        .demodEn(demodDac0En), .demodData(demodDac0Data),
        .trellisEn(trellisDac0En), .trellisData(trellisDac0Data),
        .dacSource(dac0Source),
        .dacD(dac0D)
    );

    dacPath dac1Path (
        .clk(clk), .reset(reset),
        .demodEn(demodDac1En), .demodData(demodDac1Data),
        .trellisEn(trellisDac1En), .trellisData(trellisDac1Data),
        .dacSource(dac1Source),
        .dacD(dac1D)
    );

    //**************************************************************************
    // Clock and data outputs
    //**************************************************************************

    clkDataOutput ch0Output (
        .clk(clk), .reset(reset),
        .iSymEn(iSymEn), .iSym2xEn(iSym2xEn), .iBit(iBit),
        .qSymEn(qSymEn), .qSym2xEn(qSym2xEn), .qBit(qBit),
        .trellisSymEn(trellisSymEn), .trellisSym2xEn(trellisSym2xEn),
        .trellisBit(trellisBit),
        .chSource(ch0Source),
        .chClkOut(ch0ClkOut), .chDataOut(ch0DataOut)
    );

    clkDataOutput ch1Output (
        .clk(clk), .reset(reset),
        .iSymEn(iSymEn), .iSym2xEn(iSym2xEn), .iBit(iBit),
        .qSymEn(qSymEn), .qSym2xEn(qSym2xEn), .qBit(qBit),
        .trellisSymEn(trellisSymEn), .trellisSym2xEn(trellisSym2xEn),
        .trellisBit(trellisBit),
        .chSource(ch1Source),
        .chClkOut(ch1ClkOut), .chDataOut(ch1DataOut)
    );

endmodule

/* demodOutputRouterProps.sv */
`timescale 1ns/10ps

module demodOutputRouterProps (
    input logic                clk,
    input logic                reset,
    input logic                regRead,
    input logic                regReadValid,
    input dspPkg::dacCodeT     dac0D,
    input dspPkg::dacCodeT     dac1D,
    input logic                iSymEn,
    input logic                qSymEn,
    input logic                trellisSymEn,
    input dspPkg::sourceSelT   ch0Source,
    input dspPkg::sourceSelT   ch1Source,
    input logic                ch0ClkOut,
    input logic                ch1ClkOut
);

    int failCount = 0;

    // Symbol strobe of the stream each channel listens to
    logic ch0SymSel;
    logic ch1SymSel;

    assign ch0SymSel = (ch0Source == dspPkg::CD_SRC_LEGACY_Q) ? qSymEn :
                       (ch0Source == dspPkg::CD_SRC_TRELLIS) ? trellisSymEn : iSymEn;
    assign ch1SymSel = (ch1Source == dspPkg::CD_SRC_LEGACY_Q) ? qSymEn :
                       (ch1Source == dspPkg::CD_SRC_TRELLIS) ? trellisSymEn : iSymEn;

    //**************************************************************************
    // Register bus
    //**************************************************************************

    readValidReset: assert property (@(posedge clk) reset |=> !regReadValid)
        else begin
            $error("regReadValid high after reset");
            failCount++;
        end

    readValidFollowsRead: assert property (@(posedge clk) disable iff (reset)
            regReadValid |-> $past(regRead))
        else begin
            $error("regReadValid without a read one cycle earlier");
            failCount++;
        end

    //**************************************************************************
    // Outputs
    //**************************************************************************

    dacMidscaleReset: assert property (@(posedge clk) reset |=>
            (dac0D == dspPkg::DAC_MIDSCALE && dac1D == dspPkg::DAC_MIDSCALE))
        else begin
            $error("DAC output not at midscale after reset");
            failCount++;
        end

    ch0ClkLow: assert property (@(posedge clk) disable iff (reset) ch0SymSel |=> !ch0ClkOut)
        else begin
            $error("ch0ClkOut high after a selected symbol strobe");
            failCount++;
        end

    ch1ClkLow: assert property (@(posedge clk) disable iff (reset) ch1SymSel |=> !ch1ClkOut)
        else begin
            $error("ch1ClkOut high after a selected symbol strobe");
            failCount++;
        end

endmodule

bind demodOutputRouter demodOutputRouterProps props (.*);

/* demodOutputRouterTb.sv */
`timescale 1ns/10ps

module demodOutputRouterTb;

    localparam regMapPkg::regDataT VERSION = 16'h01D4;
    localparam int DRIVE_DELAY = 1;
    localparam int DAC_LATENCY = 3;

    logic clk = 1'b0;
    logic reset;

    logic regWrite;
    logic regRead;
    regMapPkg::regAddrT regAddr;
    regMapPkg::regDataT regWriteData;
    regMapPkg::regDataT regReadData;
    logic regReadValid;

    logic demodDac0En;
    logic trellisDac0En;
    logic demodDac1En;
    logic trellisDac1En;
    dspPkg::sampleT demodDac0Data;
    dspPkg::sampleT trellisDac0Data;
    dspPkg::sampleT demodDac1Data;
    dspPkg::sampleT trellisDac1Data;

    logic iSymEn;
    logic iSym2xEn;
    logic iBit;
    logic qSymEn;
    logic qSym2xEn;
    logic qBit;
    logic trellisSymEn;
    logic trellisSym2xEn;
    logic trellisBit;

    dspPkg::dacCodeT dac0D;
    dspPkg::dacCodeT dac1D;
    logic ch0ClkOut;
    logic ch0DataOut;
    logic ch1ClkOut;
    logic ch1DataOut;

    int cycleCount = 0;
    int timeoutLimit = 0;
    int checkCount = 0;

    // DAC results still in the pipeline
    int dueQ[$];
    bit dacSelQ[$];
    dspPkg::dacCodeT codeQ[$];

    demodOutputRouter #(.VersionNumber(VERSION)) i_demodOutputRouter (.*);

    always #10 clk = ~clk;

    //**************************************************************************
    // Run control and compare tasks
    //**************************************************************************

    task automatic abortRun();
        $display("tests failed");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic checkRegData(input string name, input regMapPkg::regDataT expected,
                                input regMapPkg::regDataT actual);
        checkCount++;
        if (actual !== expected) begin
            $display("error: %s expected %h actual %h", name, expected, actual);
            abortRun();
        end
    endtask

    task automatic checkDacCode(input string name, input dspPkg::dacCodeT expected,
                                input dspPkg::dacCodeT actual);
        checkCount++;
        if (actual !== expected) begin
            $display("error: %s expected %h actual %h", name, expected, actual);
            abortRun();
        end
    endtask

    task automatic checkBit(input string name, input logic expected, input logic actual);
        checkCount++;
        if (actual !== expected) begin
            $display("error: %s expected %h actual %h", name, expected, actual);
            abortRun();
        end
    endtask

    // Bias the sample by half scale and keep the top bits
    function automatic dspPkg::dacCodeT offsetCode(input dspPkg::sampleT sample);
        logic [dspPkg::SAMPLE_WIDTH-1:0] biased;
        biased = sample + (1 << (dspPkg::SAMPLE_WIDTH - 1));
        return biased[dspPkg::SAMPLE_WIDTH-1 -: dspPkg::DAC_CODE_WIDTH];
    endfunction

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (timeoutLimit > 0 && cycleCount >= timeoutLimit) begin
            $display("cycle limit of %0d reached before the stimulus finished", timeoutLimit);
            abortRun();
        end
    end

    // DAC codes are due a fixed number of cycles after their strobe
    always @(negedge clk) begin
        while (dueQ.size() > 0 && dueQ[0] == cycleCount) begin
            if (dacSelQ[0]) begin
                checkDacCode("dac1D", codeQ[0], dac1D);
            end
            else begin
                checkDacCode("dac0D", codeQ[0], dac0D);
            end
            void'(dueQ.pop_front());
            void'(dacSelQ.pop_front());
            void'(codeQ.pop_front());
        end
    end

    // Bound assertions count their failures in the checker
    always @(negedge clk) begin
        if (i_demodOutputRouter.props.failCount != 0) begin
            $display("a bound assertion failed");
            abortRun();
        end
    end

    //**************************************************************************
    // Stimulus drivers
    //**************************************************************************

    task automatic clearStrobes();
        regWrite = 1'b0;
        regRead = 1'b0;
        demodDac0En = 1'b0;
        trellisDac0En = 1'b0;
        demodDac1En = 1'b0;
        trellisDac1En = 1'b0;
        iSymEn = 1'b0;
        iSym2xEn = 1'b0;
        qSymEn = 1'b0;
        qSym2xEn = 1'b0;
        trellisSymEn = 1'b0;
        trellisSym2xEn = 1'b0;
    endtask

    task automatic startCycle();
        @(posedge clk);
        #DRIVE_DELAY;
        clearStrobes();
    endtask

    task automatic writeReg(input regMapPkg::regAddrT addr, input regMapPkg::regDataT data);
        startCycle();
        regWrite = 1'b1;
        regAddr = addr;
        regWriteData = data;
    endtask

    // Optional write in the same cycle as the read
    task automatic readReg(input regMapPkg::regAddrT addr, input regMapPkg::regDataT expected,
                           input logic withWrite, input regMapPkg::regDataT data);
        int waited;
        waited = 0;
        startCycle();
        regRead = 1'b1;
        regWrite = withWrite;
        regAddr = addr;
        regWriteData = data;
        @(posedge clk);
        #DRIVE_DELAY;
        clearStrobes();
        @(negedge clk);
        while (!regReadValid) begin
            waited++;
            if (waited > 4) begin
                $display("read of address %h never returned a valid strobe", addr);
                abortRun();
            end
            @(negedge clk);
        end
        checkRegData("regReadData", expected, regReadData);
    endtask

    task automatic driveSample(input logic [1:0] stream, input logic strobe, input logic taken,
                               input dspPkg::sampleT sample, input dspPkg::dacCodeT code);
        if (taken && code !== offsetCode(sample)) begin
            $display("stimulus code %h for sample %h breaks the offset-binary rule",
                     code, sample);
            abortRun();
        end
        startCycle();
        case (stream)
            2'd0: begin
                demodDac0En = strobe;
                demodDac0Data = sample;
            end
            2'd1: begin
                trellisDac0En = strobe;
                trellisDac0Data = sample;
            end
            2'd2: begin
                demodDac1En = strobe;
                demodDac1Data = sample;
            end
            default: begin
                trellisDac1En = strobe;
                trellisDac1Data = sample;
            end
        endcase
        dueQ.push_back(cycleCount + DAC_LATENCY);
        dacSelQ.push_back(stream[1]);
        codeQ.push_back(code);
    endtask

    // Kind 1 is a symbol strobe, kind 2 a half-symbol strobe alone
    task automatic driveSymbol(input logic [1:0] stream, input logic [1:0] kind,
                               input logic bitValue, input logic data0, input logic clk0,
                               input logic data1, input logic clk1);
        startCycle();
        case (stream)
            2'd0: begin
                iSymEn = (kind == 2'd1);
                iSym2xEn = (kind != 2'd0);
                iBit = bitValue;
            end
            2'd1: begin
                qSymEn = (kind == 2'd1);
                qSym2xEn = (kind != 2'd0);
                qBit = bitValue;
            end
            default: begin
                trellisSymEn = (kind == 2'd1);
                trellisSym2xEn = (kind != 2'd0);
                trellisBit = bitValue;
            end
        endcase
        @(posedge clk);
        #DRIVE_DELAY;
        clearStrobes();
        @(negedge clk);
        checkBit("ch0DataOut", data0, ch0DataOut);
        checkBit("ch0ClkOut", clk0, ch0ClkOut);
        checkBit("ch1DataOut", data1, ch1DataOut);
        checkBit("ch1ClkOut", clk1, ch1ClkOut);
    endtask

    //**************************************************************************
    // Main sequence
    //**************************************************************************

    initial begin
        int fd;
        int scanCount;
        int lineCount;
        logic [7:0] cmd;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        logic [31:0] f4;
        logic [31:0] f5;
        logic [31:0] f6;
        logic [31:0] f7;
        logic [8*256-1:0] lineBuf;

        reset = 1'b1;
        clearStrobes();
        regAddr = '0;
        regWriteData = '0;
        demodDac0Data = '0;
        trellisDac0Data = '0;
        demodDac1Data = '0;
        trellisDac1Data = '0;
        iBit = 1'b0;
        qBit = 1'b0;
        trellisBit = 1'b0;

        // Cycle budget scales with the stimulus length
        lineCount = 0;
        fd = $fopen("routerStimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open routerStimulus.txt");
            abortRun();
        end
        while ($fgets(lineBuf, fd) != 0) begin
            lineCount++;
        end
        $fclose(fd);
        timeoutLimit = lineCount * 16 + 64;

        repeat (8) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;

        fd = $fopen("routerStimulus.txt", "r");
        scanCount = $fscanf(fd, " %c", cmd);
        while (scanCount == 1) begin
            case (cmd)
                "#": scanCount = $fgets(lineBuf, fd);
                "W": begin
                    scanCount = $fscanf(fd, "%h %h", f1, f2);
                    writeReg(f1, f2);
                end
                "R": begin
                    scanCount = $fscanf(fd, "%h %h", f1, f2);
                    readReg(f1, f2, 1'b0, '0);
                end
                "B": begin
                    scanCount = $fscanf(fd, "%h %h %h", f1, f2, f3);
                    readReg(f1, f3, 1'b1, f2);
                end
                "D": begin
                    scanCount = $fscanf(fd, "%h %h %h %h %h", f1, f2, f3, f4, f5);
                    driveSample(f1, f2, f3, f4, f5);
                end
                "S": begin
                    scanCount = $fscanf(fd, "%h %h %h %h %h %h %h",
                                        f1, f2, f3, f4, f5, f6, f7);
                    driveSymbol(f1, f2, f3, f4, f5, f6, f7);
                end
                "I": begin
                    scanCount = $fscanf(fd, "%h", f1);
                    repeat (f1) startCycle();
                end
                default: begin
                    $display("unknown command %c in routerStimulus.txt", cmd);
                    abortRun();
                end
            endcase
            scanCount = $fscanf(fd, " %c", cmd);
        end
        $fclose(fd);

        startCycle();
        while (dueQ.size() > 0) begin
            @(negedge clk);
        end

        if (checkCount == 0 || i_demodOutputRouter.props.failCount != 0) begin
            $display("no checks ran or a bound assertion failed");
            abortRun();
        end
        else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

/* routerStimulus.txt */
# W addr data | R addr expected | B addr writeData expectedOld | I idleCycles
# D stream(0 demod0 1 trellis0 2 demod1 3 trellis1) strobe taken sample code
# S stream(0 I 1 Q 2 trellis) kind(1 symbol 2 half) bit ch0Data ch0Clk ch1Data ch1Clk
R 0 01d4
R 1 0000
R 2 0000
R 3 0000
R 4 0000
D 0 0 0 00000 2000
D 2 0 0 00000 2000
S 0 0 0 0 0 0 0
I 3
# register access
W 1 00a5
R 1 0005
W 2 1234
R 2 0004
W 0 ffff
R 0 01d4
R 7 0000
R f 0000
B 1 0003 0005
R 1 0003
W 1 0000
W 2 0000
# DAC conversion and hold on the demod source
D 0 1 1 1ffff 3fff
D 0 1 1 20000 0000
D 0 1 1 00000 2000
D 0 1 1 12345 3234
D 0 0 0 0abcd 3234
D 2 1 1 3a5c0 1a5c
I 4
# DAC steering
W 1 0001
D 0 1 0 11110 3234
D 1 1 1 04440 2444
D 2 1 1 08880 2888
D 3 1 0 1fff0 2888
I 4
W 1 0007
R 1 0007
D 0 1 1 2fff0 0fff
D 1 1 0 00100 0fff
I 4
# clock and data, ch0 legacy I and ch1 legacy Q
W 3 0000
W 4 0001
S 0 1 1 1 0 0 0
S 0 2 0 1 1 0 0
S 1 1 1 1 1 1 0
S 1 2 0 1 1 1 1
S 2 1 0 1 1 1 1
S 0 1 0 0 0 1 1
# ch0 trellis and ch1 legacy I
W 3 0002
W 4 0000
S 2 1 1 1 0 1 1
S 2 2 0 1 1 1 1
S 0 1 0 1 1 0 0
S 0 2 1 1 1 0 1
# ch0 legacy Q and ch1 trellis
W 3 0001
W 4 0002
S 1 1 0 0 0 0 1
S 1 2 0 0 1 0 1
S 2 1 1 0 1 1 0
S 2 2 0 0 1 1 1
# selects outside the enum follow legacy I
W 3 0009
W 4 000f
S 1 1 1 0 1 1 1
S 0 1 1 1 0 1 0
S 0 2 0 1 1 1 1

/* project.f */
dspPkg.sv
regMapPkg.sv
routerRegs.sv
dacPath.sv
clkDataOutput.sv
demodOutputRouter.sv
demodOutputRouterProps.sv
demodOutputRouterTb.sv
